// ==== hdl/bb_io_pkg.sv ====
// ----------------------------------------------------------------------
// I/O blackbox line definitions: widths, line vectors, processing modes
// ----------------------------------------------------------------------

package bb_io_pkg;

	// Largest supported number of DIOB lines
	localparam int max_lines = 16;

	// One bit per DIOB line, narrower designs use the low bits
	typedef logic [max_lines-1:0] line_vec_t;

	// Raw mode code of one line, one nibble in a select register
	typedef logic [3:0] mode_sel_t;

	// Decoded processing modes, codes 4 to 15 are unknown
	typedef enum logic [1:0]
	{
		proc_off         = 2'd0,
		proc_in_pass     = 2'd1,
		proc_out         = 2'd2,
		proc_in_debounce = 2'd3
	} proc_mode_t;

	// Debounce FSM
	typedef enum logic
	{
		deb_stable   = 1'b0,	// Output equals input
		deb_counting = 1'b1		// Input differs, counting ticks
	} deb_state_t;

	// Debounce counter
	typedef logic [15:0] count_t;

endpackage

// ==== hdl/bb_bus_pkg.sv ====
// ----------------------------------------------------------------------
// Strobe bus of the I/O blackbox: words, request/response, register map
// ----------------------------------------------------------------------

package bb_bus_pkg;

	typedef logic [15:0] bus_addr_t;
	typedef logic [15:0] bus_data_t;

	// Master to slave, triggers are single-cycle pulses
	typedef struct packed
	{
		bus_addr_t addr;
		bus_data_t data_w;
		logic      read_trg;
		logic      write_trg;
	} bus_req_t;

	// Slave to master, one cycle after the trigger
	typedef struct packed
	{
		bus_data_t data_r;
		logic      dtack;
		logic      data_r_act;	// data_r valid
	} bus_rsp_t;

	// Word offsets inside the register window
	localparam bus_addr_t reg_version   = 16'd0;
	localparam bus_addr_t reg_status    = 16'd1;
	localparam bus_addr_t reg_input     = 16'd2;
	localparam bus_addr_t reg_gpio_out  = 16'd3;
	localparam bus_addr_t reg_proc_sel0 = 16'd4;	// Offsets 4 to 7, four lines each

	// Size of the register window
	localparam int nr_regs = 8;

	// Version word is {major, minor}
	localparam logic [7:0] bb_version_major = 8'd1;
	localparam logic [7:0] bb_version_minor = 8'd2;

endpackage

// ==== hdl/diob_frontend.sv ====
// ----------------------------------------------------------------------
// DIOB frontend: two-flop input synchronizer, registered output/direction
// ----------------------------------------------------------------------

module diob_frontend import bb_io_pkg::*;
#(
	parameter int nr_lines = 8
)
(
	input  logic      clock,
	input  logic      reset,
	input  line_vec_t diob_in,
	output line_vec_t diob_sync,
	input  line_vec_t line_out,
	input  line_vec_t line_oe,
	output line_vec_t diob_out,
	output line_vec_t diob_dir
);

	// Only the lines that exist
	localparam line_vec_t lines_mask = line_vec_t'((1 << nr_lines) - 1);

	line_vec_t sync_meta;	// First stage, may go metastable

	// Input synchronizer
	always_ff @(posedge clock)
	begin
		sync_meta <= diob_in & lines_mask;
		diob_sync <= sync_meta;
	end

	// Output registers
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			diob_out <= '0;
			diob_dir <= '0;
		end
		else
		begin
			diob_out <= line_out & line_oe & lines_mask;	// Undriven lines stay low
			diob_dir <= line_oe & lines_mask;
		end
	end

endmodule

// ==== hdl/proc_line.sv ====
// ----------------------------------------------------------------------
// One line's processing: off, input pass, output or input debounce
// ----------------------------------------------------------------------

module proc_line import bb_io_pkg::*;
#(
	parameter int debounce_ticks = 5
)
(
	input  logic       clock,
	input  logic       reset,
	input  proc_mode_t mode,
	input  logic       sync_in,
	input  logic       gpio_bit,
	output logic       virt_bit,
	output logic       out_bit,
	output logic       oe_bit
);

	localparam count_t last_tick = count_t'(debounce_ticks - 1);

	deb_state_t deb_state;
	count_t     deb_count;	// Consecutive cycles with a differing level
	logic       level_differs;

	assign level_differs = sync_in != virt_bit;

	// Output side is combinational from mode and gpio value
	assign oe_bit  = mode == proc_out;
	assign out_bit = (mode == proc_out) && gpio_bit;

	// ------------------------------------------------------------------
	// Input side
	// ------------------------------------------------------------------

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			virt_bit  <= 1'b0;
			deb_state <= deb_stable;
			deb_count <= '0;
		end
		else if (mode == proc_in_debounce)
		begin
			case (deb_state)
				deb_stable:
				begin
					if (level_differs)
					begin
						if (debounce_ticks <= 1)
							virt_bit <= sync_in;	// No filtering at all
						else
						begin
							deb_state <= deb_counting;
							deb_count <= count_t'(1);
						end
					end
				end
				deb_counting:
				begin
					if (!level_differs)
					begin
						// Input went back, start over
						deb_state <= deb_stable;
						deb_count <= '0;
					end
					else if (deb_count == last_tick)
					begin
						virt_bit  <= sync_in;
						deb_state <= deb_stable;
						deb_count <= '0;
					end
					else
						deb_count <= deb_count + count_t'(1);
				end
				default:
				begin
					deb_state <= deb_stable;
					deb_count <= '0;
				end
			endcase
		end
		else
		begin
			// Any other mode parks the debouncer
			deb_state <= deb_stable;
			deb_count <= '0;
			virt_bit  <= (mode == proc_in_pass) ? sync_in : 1'b0;
		end
	end

endmodule

// ==== hdl/proc_bank.sv ====
// ----------------------------------------------------------------------
// Processing bank: decodes per-line mode selects, one channel per line
// ----------------------------------------------------------------------

module proc_bank import bb_io_pkg::*;
#(
	parameter int nr_lines       = 8,
	parameter int debounce_ticks = 5
)
(
	input  logic                     clock,
	input  logic                     reset,
	input  mode_sel_t [nr_lines-1:0] proc_sel,
	input  line_vec_t                gpio_out,
	input  line_vec_t                diob_sync,
	output line_vec_t                virt_in,
	output line_vec_t                line_out,
	output line_vec_t                line_oe,
	output logic                     any_unknown_sel
);

	logic [nr_lines-1:0] unknown_sel;	// Per line, code outside 0..3

	assign any_unknown_sel = |unknown_sel;

	for (genvar i = 0; i < max_lines; i++)
	begin : g_line
		if (i < nr_lines)
		begin : g_used
			proc_mode_t mode;
			logic       unknown;

			// Unknown codes fall back to off
			always_comb
			begin
				unknown = 1'b0;
				case (proc_sel[i])
					4'd0: mode = proc_off;
					4'd1: mode = proc_in_pass;
					4'd2: mode = proc_out;
					4'd3: mode = proc_in_debounce;
					default:
					begin
						mode    = proc_off;
						unknown = 1'b1;
					end
				endcase
			end

			assign unknown_sel[i] = unknown;

			proc_line #(
				.debounce_ticks	(debounce_ticks)
			) line_inst (
				.clock		(clock),
				.reset		(reset),
				.mode		(mode),
				.sync_in	(diob_sync[i]),
				.gpio_bit	(gpio_out[i]),
				.virt_bit	(virt_in[i]),
				.out_bit	(line_out[i]),
				.oe_bit		(line_oe[i])
			);
		end
		else
		begin : g_unused
			assign virt_in[i]  = 1'b0;
			assign line_out[i] = 1'b0;
			assign line_oe[i]  = 1'b0;
		end
	end

endmodule

// ==== hdl/blackbox_regs.sv ====
// ----------------------------------------------------------------------
// Register block on the strobe bus: version, status, inputs, gpio, selects
// ----------------------------------------------------------------------

module blackbox_regs import bb_io_pkg::*, bb_bus_pkg::*;
#(
	parameter int        nr_lines  = 8,
	parameter bus_addr_t base_addr = 16'h0100
)
(
	input  logic                     clock,
	input  logic                     reset,
	input  bus_req_t                 bus_req,
	output bus_rsp_t                 bus_rsp,
	input  line_vec_t                virt_in,
	input  logic                     any_unknown_sel,
	output line_vec_t                gpio_out,
	output mode_sel_t [nr_lines-1:0] proc_sel
);

	localparam line_vec_t lines_mask = line_vec_t'((1 << nr_lines) - 1);

	bus_addr_t                 offset;		// Word offset from base_addr
	bus_addr_t                 sel_offset;	// Offset from the first select register
	logic [1:0]                sel_idx;
	logic                      hit;
	mode_sel_t [max_lines-1:0] sel_all;		// Selects padded to the full window
	bus_data_t [3:0]           sel_words;
	bus_data_t                 read_word;
	bus_data_t                 data_r_q;
	logic                      dtack_q;
	logic                      data_r_act_q;

	// ------------------------------------------------------------------
	// Address check
	// ------------------------------------------------------------------

	assign offset     = bus_req.addr - base_addr;
	assign sel_offset = offset - reg_proc_sel0;
	assign sel_idx    = sel_offset[1:0];
	assign hit        = (bus_req.addr >= base_addr) && (offset < bus_addr_t'(nr_regs));

	// ------------------------------------------------------------------
	// Read mux
	// ------------------------------------------------------------------

	always_comb
	begin
		sel_all                 = '0;
		sel_all[nr_lines-1:0]   = proc_sel;
	end

	assign sel_words = sel_all;	// Lowest line in the low nibble

	always_comb
	begin
		read_word = '0;
		case (offset)
			reg_version:  read_word = {bb_version_major, bb_version_minor};
			reg_status:   read_word = bus_data_t'(any_unknown_sel);
			reg_input:    read_word = bus_data_t'(virt_in);
			reg_gpio_out: read_word = bus_data_t'(gpio_out);
			default:
			begin
				if (offset >= reg_proc_sel0)
					read_word = sel_words[sel_idx];
			end
		endcase
	end

	// ------------------------------------------------------------------
	// Register writes and handshake
	// ------------------------------------------------------------------

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			gpio_out     <= '0;
			proc_sel     <= '0;	// All lines off
			dtack_q      <= 1'b0;
			data_r_act_q <= 1'b0;
		end
		else
		begin
			dtack_q      <= hit && (bus_req.read_trg || bus_req.write_trg);
			data_r_act_q <= hit && bus_req.read_trg;

			if (hit && bus_req.write_trg)
			begin
				if (offset == reg_gpio_out)
					gpio_out <= bus_req.data_w & lines_mask;
				else if (offset >= reg_proc_sel0)
				begin
					// Selects beyond nr_lines are ignored
					for (int j = 0; j < nr_lines; j++)
					begin
						if (j / 4 == sel_idx)
							proc_sel[j] <= bus_req.data_w[(j % 4) * 4 +: 4];
					end
				end
			end
		end
	end

	// Read data, sampled with the trigger
	always_ff @(posedge clock)
	begin
		if (hit && bus_req.read_trg)
			data_r_q <= read_word;
	end

	assign bus_rsp = '{data_r: data_r_q, dtack: dtack_q, data_r_act: data_r_act_q};

endmodule

// ==== hdl/io_blackbox.sv ====
// ----------------------------------------------------------------------
// I/O blackbox top level: DIOB frontend, line processing, register block
// ----------------------------------------------------------------------

module io_blackbox import bb_io_pkg::*, bb_bus_pkg::*;
#(
	parameter int        nr_lines       = 8,		// 4 to 16, multiple of 4
	parameter bus_addr_t base_addr      = 16'h0100,
	parameter int        debounce_ticks = 5
)
(
	input  logic      clock,
	input  logic      reset,
	input  line_vec_t diob_in,
	output line_vec_t diob_out,
	output line_vec_t diob_dir,
	input  bus_req_t  bus_req,
	output bus_rsp_t  bus_rsp
);

	line_vec_t                  diob_sync;
	line_vec_t                  line_out;
	line_vec_t                  line_oe;
	line_vec_t                  virt_in;
	line_vec_t                  gpio_out;
	mode_sel_t [nr_lines-1:0]   proc_sel;
	logic                       any_unknown_sel;

	diob_frontend #(
		.nr_lines	(nr_lines)
	) frontend_inst (
		.clock		(clock),
		.reset		(reset),
		.diob_in	(diob_in),
		.diob_sync	(diob_sync),
		.line_out	(line_out),
		.line_oe	(line_oe),
		.diob_out	(diob_out),
		.diob_dir	(diob_dir)
	);

	proc_bank #(
		.nr_lines		(nr_lines),
		.debounce_ticks	(debounce_ticks)
	) proc_bank_inst (
		.clock				(clock),
		.reset				(reset),
		.proc_sel			(proc_sel),
		.gpio_out			(gpio_out),
		.diob_sync			(diob_sync),
		.virt_in			(virt_in),
		.line_out			(line_out),
		.line_oe			(line_oe),
		.any_unknown_sel	(any_unknown_sel)
	);

	blackbox_regs #(
		.nr_lines	(nr_lines),
		.base_addr	(base_addr)
	) regs_inst (
		.clock				(clock),
		.reset				(reset),
		.bus_req			(bus_req),
		.bus_rsp			(bus_rsp),
		.virt_in			(virt_in),
		.any_unknown_sel	(any_unknown_sel),
		.gpio_out			(gpio_out),
		.proc_sel			(proc_sel)
	);

endmodule

// ==== tests/io_blackbox_properties.sv ====
// ----------------------------------------------------------------------
// Bus handshake and DIOB direction assertions, bound into the design
// ----------------------------------------------------------------------

module io_blackbox_properties import bb_io_pkg::*, bb_bus_pkg::*;
(
	input logic      clock,
	input logic      reset,
	input bus_req_t  bus_req,
	input bus_rsp_t  bus_rsp,
	input line_vec_t diob_dir
);

	// Single-cycle acknowledge
	dtack_single: assert property (@(posedge clock) disable iff (reset)
		bus_rsp.dtack |=> !bus_rsp.dtack)
		else $error("dtack high for two consecutive cycles");

	// Acknowledge only one cycle after a trigger
	dtack_after_trigger: assert property (@(posedge clock) disable iff (reset)
		bus_rsp.dtack |-> $past(bus_req.read_trg || bus_req.write_trg))
		else $error("dtack without a trigger in the previous cycle");

	// First reset edge loads the output registers
	dir_idle_in_reset: assert property (@(posedge clock)
		(reset && $past(reset)) |-> (diob_dir == '0))
		else $error("diob_dir not zero during reset");

endmodule

bind blackbox_regs io_blackbox_properties regs_props (.clock(clock), .reset(reset),
	.bus_req(bus_req), .bus_rsp(bus_rsp), .diob_dir('0));

bind diob_frontend io_blackbox_properties frontend_props (.clock(clock), .reset(reset),
	.bus_req('0), .bus_rsp('0), .diob_dir(diob_dir));

// ==== tests/io_blackbox_tb.sv ====
// ----------------------------------------------------------------------
// Testbench for the I/O blackbox: bus access, line modes, address window
// ----------------------------------------------------------------------

module io_blackbox_tb import bb_io_pkg::*, bb_bus_pkg::*;
();

	localparam int        nr_lines       = 8;
	localparam bus_addr_t base_addr      = 16'h0100;
	localparam int        debounce_ticks = 5;
	localparam int        bus_timeout    = 8;	// Cycles to wait for dtack

	logic      clock;
	logic      reset;
	line_vec_t diob_in;
	line_vec_t diob_out;
	line_vec_t diob_dir;
	bus_req_t  bus_req;
	bus_rsp_t  bus_rsp;
	int        errors = 0;
	int        tests_run = 0;
	int        tests_failed = 0;

	io_blackbox #(
		.nr_lines		(nr_lines),
		.base_addr		(base_addr),
		.debounce_ticks	(debounce_ticks)
	) dut (
		.clock		(clock),
		.reset		(reset),
		.diob_in	(diob_in),
		.diob_out	(diob_out),
		.diob_dir	(diob_dir),
		.bus_req	(bus_req),
		.bus_rsp	(bus_rsp)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// ------------------------------------------------------------------
	// Bus access and helpers
	// ------------------------------------------------------------------

	task automatic report_error(input string msg);
		$display("** Error at %0t: %s", $time, msg);
		errors++;
	endtask

	// One trigger, then wait for dtack sampled at the falling edge
	task automatic bus_access(input logic is_write, input bus_addr_t addr,
		input bus_data_t data, output logic acked, output bus_data_t rdata);
		int cycles;
		cycles = 0;
		acked  = 1'b0;
		rdata  = '0;
		@(posedge clock);
		bus_req.addr      <= addr;
		bus_req.data_w    <= data;
		bus_req.write_trg <= is_write;
		bus_req.read_trg  <= !is_write;
		@(posedge clock);
		bus_req.write_trg <= 1'b0;
		bus_req.read_trg  <= 1'b0;
		while (!acked && cycles < bus_timeout)
		begin
			@(negedge clock);
			if (bus_rsp.dtack)
			begin
				acked = 1'b1;
				rdata = bus_rsp.data_r;
				if (!is_write && !bus_rsp.data_r_act)
					report_error("data_r_act low on a read acknowledge");
			end
			else
				cycles++;
		end
	endtask

	task automatic bus_write(input bus_addr_t offset, input bus_data_t data);
		logic      acked;
		bus_data_t unused;
		bus_access(1'b1, base_addr + offset, data, acked, unused);
		if (!acked)
		begin
			$display("Timeout: write to offset %0d was never acknowledged", offset);
			errors++;
		end
	endtask

	task automatic bus_read(input bus_addr_t offset, output bus_data_t data);
		logic acked;
		bus_access(1'b0, base_addr + offset, '0, acked, data);
		if (!acked)
		begin
			$display("Timeout: read of offset %0d was never acknowledged", offset);
			errors++;
		end
	endtask

	task automatic check_reg(input bus_addr_t offset, input bus_data_t expected, input string name);
		bus_data_t data;
		bus_read(offset, data);
		if (data !== expected)
			report_error($sformatf("%s read %h, expected %h", name, data, expected));
	endtask

	// Two select words cover the eight lines
	task automatic write_modes(input logic [31:0] modes);
		bus_write(reg_proc_sel0, modes[15:0]);
		bus_write(reg_proc_sel0 + 16'd1, modes[31:16]);
	endtask

	function automatic line_vec_t lines_with_code(input logic [31:0] modes, input mode_sel_t code);
		line_vec_t mask;
		mask = '0;
		for (int i = 0; i < nr_lines; i++)
			if (modes[i*4 +: 4] == code)
				mask[i] = 1'b1;
		return mask;
	endfunction

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before)
			$display("Test %s: passed", name);
		else
		begin
			tests_failed++;
			$display("Test %s: FAILED with %0d errors", name, errors - errors_before);
		end
	endtask

	// ------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------

	task automatic test_reset_id();
		int e0;
		e0 = errors;
		@(negedge clock);
		if (diob_dir !== '0 || diob_out !== '0)
			report_error("DIOB outputs not zero after reset");
		check_reg(reg_version, {bb_version_major, bb_version_minor}, "version");
		check_reg(reg_status, 16'h0000, "status");
		finish_test("reset_id", e0);
	endtask

	task automatic test_readback();
		int          e0;
		logic [31:0] modes;
		bus_data_t   gpio;
		bus_data_t   data;
		e0    = errors;
		modes = '0;
		for (int i = 0; i < nr_lines; i++)
			modes[i*4 +: 4] = 4'($urandom % 4);
		gpio = 16'($urandom);
		write_modes(modes);
		bus_write(reg_gpio_out, gpio);
		check_reg(reg_proc_sel0, modes[15:0], "select 0");
		check_reg(reg_proc_sel0 + 16'd1, modes[31:16], "select 1");
		check_reg(reg_gpio_out, gpio & 16'h00FF, "gpio_out");
		// Unknown code on line 2 with pin and gpio high
		@(posedge clock);
		diob_in <= '1;
		bus_write(reg_gpio_out, 16'hFFFF);
		modes[11:8] = 4'd9;
		write_modes(modes);
		check_reg(reg_status, 16'h0001, "status after unknown code");
		if (diob_dir[2] !== 1'b0 || diob_out[2] !== 1'b0)
			report_error("line with unknown code is driven");
		bus_read(reg_input, data);
		if (data[2] !== 1'b0)
			report_error("line with unknown code reads nonzero");
		modes[11:8] = 4'd1;
		write_modes(modes);
		check_reg(reg_status, 16'h0000, "status after valid code");
		finish_test("readback", e0);
	endtask

	task automatic test_output();
		int          e0;
		int          cycles;
		logic [31:0] modes;
		line_vec_t   mask;
		bus_data_t   gpio;
		e0     = errors;
		cycles = 0;
		modes  = 32'h0220_2002;		// Lines 0, 3, 5 and 6 drive
		mask   = lines_with_code(modes, 4'd2);
		gpio   = 16'($urandom) & 16'h00FF;
		write_modes(modes);
		bus_write(reg_gpio_out, gpio);
		while ((diob_dir !== mask || diob_out !== (gpio & mask)) && cycles < 10)
		begin
			@(negedge clock);
			cycles++;
		end
		if (diob_dir !== mask)
			report_error($sformatf("diob_dir is %h, expected %h", diob_dir, mask));
		if (diob_out !== (gpio & mask))
			report_error($sformatf("diob_out is %h, expected %h", diob_out, gpio & mask));
		finish_test("output", e0);
	endtask

	task automatic test_input_pass();
		int          e0;
		int          reads;
		logic [31:0] modes;
		line_vec_t   pass_mask;
		line_vec_t   stim;
		bus_data_t   expected;
		bus_data_t   data;
		e0        = errors;
		reads     = 0;
		modes     = 32'h1001_0112;	// Lines 1, 2, 4, 7 pass and line 0 drives
		pass_mask = lines_with_code(modes, 4'd1);
		stim      = line_vec_t'($urandom) | ~pass_mask;	// Other pins high
		expected  = stim & pass_mask;
		write_modes(modes);
		@(posedge clock);
		diob_in <= stim;
		do
		begin
			bus_read(reg_input, data);
			reads++;
		end
		while (data !== expected && reads < 8);
		if (data !== expected)
			report_error($sformatf("input reads %h, expected %h", data, expected));
		finish_test("input_pass", e0);
	endtask

	task automatic test_debounce();
		int        e0;
		bus_data_t data;
		e0 = errors;
		@(posedge clock);
		diob_in <= '0;
		write_modes(32'h0000_3000);		// Line 3 filtered
		repeat (4) @(posedge clock);
		fork
			begin
				diob_in[3] <= 1'b1;
				repeat (3) @(posedge clock);	// Shorter than debounce_ticks
				diob_in[3] <= 1'b0;
			end
			begin
				// Poll through the pulse and a few cycles beyond
				repeat (6)
				begin
					bus_read(reg_input, data);
					if (data !== 16'h0000)
						report_error($sformatf("input reads %h during short pulse", data));
				end
			end
		join
		@(posedge clock);
		diob_in[3] <= 1'b1;
		repeat (10) @(posedge clock);
		check_reg(reg_input, 16'h0008, "input after held level");
		finish_test("debounce", e0);
	endtask

	task automatic test_window();
		int        e0;
		logic      acked;
		bus_data_t data;
		bus_data_t gpio_before;
		bus_data_t sel_before;
		e0 = errors;
		bus_read(reg_gpio_out, gpio_before);
		bus_read(reg_proc_sel0, sel_before);
		bus_access(1'b1, base_addr - 16'd1, ~gpio_before, acked, data);
		if (acked)
			report_error("write below the register window was acknowledged");
		bus_access(1'b0, base_addr + bus_addr_t'(nr_regs), '0, acked, data);
		if (acked)
			report_error("read above the register window was acknowledged");
		check_reg(reg_gpio_out, gpio_before, "gpio_out after outside accesses");
		check_reg(reg_proc_sel0, sel_before, "select 0 after outside accesses");
		finish_test("window", e0);
	endtask

	// ------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------

	initial
	begin
		void'($urandom(48));
		reset   = 1'b1;
		diob_in = '0;
		bus_req = '0;
		repeat (8) @(posedge clock);
		reset <= 1'b0;

		test_reset_id();
		test_readback();
		test_output();
		test_input_pass();
		test_debounce();
		test_window();

		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== io_blackbox.f ====
hdl/bb_io_pkg.sv
hdl/bb_bus_pkg.sv
hdl/diob_frontend.sv
hdl/proc_line.sv
hdl/proc_bank.sv
hdl/blackbox_regs.sv
hdl/io_blackbox.sv
tests/io_blackbox_properties.sv
tests/io_blackbox_tb.sv
